/* project.f */
+incdir+src
src/gc_pkg.sv
src/gc_regs.sv
src/netlist_mem.sv
src/label_gen.sv
src/wire_labels.sv
src/gc_garbler.sv
src/gc_top.sv
sim/tb_gc.sv

/* run.sh */
#!/bin/bash
# Build the garbler testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_gc -f project.f -o sim_gc \
	&& ./obj_dir/sim_gc > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* sim/tb_gc.sv */
// Garbler testbench driving AXI4-Lite, collecting the output stream and checking a model
`include "gc_cfg.svh"

module tb_gc;
	import gc_pkg::*;

	localparam int NUM_CASES = 6;

	typedef struct packed {
		logic [31:0] seed;
		logic [7:0]  num_in;
		logic [7:0]  num_gates;
		logic [7:0]  num_out;
		logic [1:0]  ops;     // 0 XOR, 1 XNOR, 2 NOT, 3 mixed
		logic        fixed;   // Gate g reads inputs g and g+1
	} case_t;

	// Cases 1 to 3 share seed and wiring and differ only in the gate type
	case_t cases [NUM_CASES] = '{
		'{32'h1234_5678, 8'd4, 8'd6,  8'd3,  2'd0, 1'b0},
		'{32'h0bad_cafe, 8'd3, 8'd5,  8'd5,  2'd0, 1'b1},
		'{32'h0bad_cafe, 8'd3, 8'd5,  8'd5,  2'd1, 1'b1},
		'{32'h0bad_cafe, 8'd3, 8'd5,  8'd5,  2'd2, 1'b1},
		'{32'h9e37_79b9, 8'd8, 8'd40, 8'd32, 2'd3, 1'b0},
		'{32'h0000_0001, 8'd2, 8'd1,  8'd1,  2'd3, 1'b0}
	};

	logic                      clk;
	logic                      rst;
	logic [`GC_AXI_ADDR_W-1:0] awaddr;
	logic [`GC_AXI_ADDR_W-1:0] araddr;
	logic                      awvalid, wvalid, bready, arvalid, rready;
	logic                      awready, wready, bvalid, arready, rvalid;
	logic [31:0]               wdata;
	logic [31:0]               rdata;
	logic [3:0]                wstrb;
	logic [1:0]                bresp, rresp;
	tag_t                      out_tag;
	wire_idx_t                 out_index;
	label_t                    out_data;

	tag_t        beat_tag [$];
	wire_idx_t   beat_index [$];
	label_t      beat_data [$];
	label_t      lab [256];     // Model zero-labels by wire
	gate_word_t  gates [256];
	logic [31:0] rand_state;

	gc_top UUT (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Stream beats are registered, so sample them mid-cycle
	always @(negedge clk) begin
		if (!rst && out_tag != TAG_NONE) begin
			beat_tag.push_back(out_tag);
			beat_index.push_back(out_index);
			beat_data.push_back(out_data);
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int cycle_budget();
		int n;
		n = 200;   // Reset and the first register checks
		for (int k = 0; k < NUM_CASES; k++)
			n += 10 * int'(cases[k].num_gates) + 4 * int'(cases[k].num_in)
				+ 4 * int'(cases[k].num_out) + 200;
		return n;
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Errors found");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic axi_write(input logic [`GC_AXI_ADDR_W-1:0] addr, input logic [31:0] data);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hf;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		bready  = 1'b1;
		while (!(awready && wready))
			step();
		step();                      // Address and data accepted here
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
			step();
		check("bresp", 32'(bresp), 32'd0);
		step();
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [`GC_AXI_ADDR_W-1:0] addr, output logic [31:0] data);
		araddr  = addr;
		arvalid = 1'b1;
		rready  = 1'b1;
		while (!arready)
			step();
		step();
		arvalid = 1'b0;
		while (!rvalid)
			step();
		check("rresp", 32'(rresp), 32'd0);
		data = rdata;
		step();
		rready = 1'b0;
	endtask

	task automatic load_case(input case_t c);
		int          ni;
		int          in0;
		int          in1;
		int          op;
		logic [31:0] v;
		ni = int'(c.num_in);
		axi_write(`GC_REG_SEED, c.seed);
		axi_write(`GC_REG_NUM_IN, 32'(c.num_in));
		axi_write(`GC_REG_NUM_GATES, 32'(c.num_gates));
		axi_write(`GC_REG_NUM_OUT, 32'(c.num_out));
		axi_write(`GC_REG_GATE_ADDR, 32'd0);
		for (int g = 0; g < int'(c.num_gates); g++) begin
			if (c.fixed) begin
				in0 = 2 + g % ni;
				in1 = 2 + (g + 1) % ni;
			end else begin
				rand_state = xorshift32(rand_state);
				in0 = int'(rand_state % (2 + ni + g));   // Any earlier wire
				rand_state = xorshift32(rand_state);
				in1 = int'(rand_state % (2 + ni + g));
			end
			op = int'(c.ops);
			if (c.ops == 2'd3) begin
				rand_state = xorshift32(rand_state);
				op = int'(rand_state % 3);
			end
			gates[g] = {2'(op), 8'(in0), 8'(in1)};
			axi_write(`GC_REG_GATE_DATA, 32'(gates[g]));
		end
		axi_read(`GC_REG_SEED, v);
		check("seed", v, c.seed);
		axi_read(`GC_REG_NUM_IN, v);
		check("num_in", v, 32'(c.num_in));
		axi_read(`GC_REG_NUM_GATES, v);
		check("num_gates", v, 32'(c.num_gates));
		axi_read(`GC_REG_NUM_OUT, v);
		check("num_out", v, 32'(c.num_out));
		axi_read(`GC_REG_GATE_ADDR, v);
		check("gate_addr", v, 32'(c.num_gates));
	endtask

	// Garbler model with the label draws, free-XOR gates and output mask
	task automatic compute_expected(input case_t c, output label_t r, output label_t mask);
		logic [31:0] s;
		label_t      a;
		label_t      b;
		int          ni;
		int          base;
		ni = int'(c.num_in);
		s  = xorshift32(c.seed);
		r  = s | 32'd1;
		for (int w = 0; w < ni + 2; w++) begin
			s = xorshift32(s);
			lab[w] = s;
		end
		for (int g = 0; g < int'(c.num_gates); g++) begin
			a = lab[gates[g][15:8]];
			b = lab[gates[g][7:0]];
			case (gates[g][17:16])
				2'd1:    lab[2 + ni + g] = a ^ b ^ r;
				2'd2:    lab[2 + ni + g] = a ^ r;
				default: lab[2 + ni + g] = a ^ b;
			endcase
		end
		base = 2 + ni + int'(c.num_gates) - int'(c.num_out);
		mask = '0;
		for (int i = 0; i < int'(c.num_out); i++)
			mask[i] = lab[base + i][0];
	endtask

	task automatic run_case(input int k);
		case_t       c;
		label_t      r;
		label_t      mask;
		logic [31:0] v;
		int          last;
		c = cases[k];
		load_case(c);
		compute_expected(c, r, mask);
		beat_tag.delete();
		beat_index.delete();
		beat_data.delete();
		axi_write(`GC_REG_CTRL, 32'd1);
		axi_write(`GC_REG_CTRL, 32'd1);   // Lands while busy and starts no second run
		while (!(beat_tag.size() > 0 && beat_tag[beat_tag.size() - 1] == TAG_MASK))
			step();
		repeat (4) step();
		check("beat count", 32'(beat_tag.size()), 32'(int'(c.num_in) + 4));
		check("out_tag", 32'(beat_tag[0]), 32'(TAG_R));
		check("out_index", 32'(beat_index[0]), 32'd0);
		check("out_data R", beat_data[0], r);
		for (int w = 0; w < int'(c.num_in) + 2; w++) begin
			check("out_tag", 32'(beat_tag[w + 1]), 32'(TAG_LABEL));
			check("out_index", 32'(beat_index[w + 1]), 32'(w));
			check("out_data label", beat_data[w + 1], lab[w]);
		end
		last = beat_tag.size() - 1;
		check("out_tag", 32'(beat_tag[last]), 32'(TAG_MASK));
		check("out_data mask", beat_data[last], mask);
		axi_read(`GC_REG_STATUS, v);
		check("status", v, 32'd2);   // Done and not busy
	endtask

	initial begin
		logic [31:0] v;
		rst        = 1'b1;
		awaddr     = '0;
		awvalid    = 1'b0;
		wdata      = '0;
		wstrb      = '0;
		wvalid     = 1'b0;
		bready     = 1'b0;
		araddr     = '0;
		arvalid    = 1'b0;
		rready     = 1'b0;
		rand_state = 32'hc3be;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		axi_read(`GC_REG_STATUS, v);
		check("status", v, 32'd0);
		axi_read(6'h20, v);   // Unmapped
		check("unmapped", v, 32'd0);
		for (int k = 0; k < NUM_CASES; k++)
			run_case(k);
		$display("No errors");
		$finish;
	end

	initial begin : watchdog
		#(cycle_budget() * 10);
		$display("Timeout: the garbler runs did not complete in time");
		$display("Errors found");
		$fatal(1, "watchdog expired");
	end

endmodule

/* src/gc_top.sv */
// Garbler top level with the register block beside the garbler FSM and its memories
`include "gc_cfg.svh"

module gc_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [`GC_AXI_ADDR_W-1:0]   awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [31:0]                 wdata,
	input  logic [3:0]                  wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [1:0]                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [`GC_AXI_ADDR_W-1:0]   araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [31:0]                 rdata,
	output logic [1:0]                  rresp,
	output logic                        rvalid,
	input  logic                        rready,
	output gc_pkg::tag_t                out_tag,
	output gc_pkg::wire_idx_t           out_index,
	output gc_pkg::label_t              out_data
);
	import gc_pkg::*;

	logic       start, busy, done;
	label_t     seed;
	wire_idx_t  num_in, num_out;
	gate_idx_t  num_gates;
	logic       gate_wr_en;
	gate_idx_t  gate_wr_addr, gate_addr;
	gate_word_t gate_wr_data, gate_word;
	logic       gen_load, gen_step;
	label_t     gen_label;
	logic       lbl_wr_en;
	wire_idx_t  lbl_wr_addr, lbl_rd_addr_0, lbl_rd_addr_1;
	label_t     lbl_wr_data, lbl_rd_data_0, lbl_rd_data_1;

	// Control path from the host
	gc_regs u_regs (.*);

	netlist_mem u_netlist (
		.clk     (clk),
		.wr_en   (gate_wr_en),
		.wr_addr (gate_wr_addr),
		.wr_data (gate_wr_data),
		.rd_addr (gate_addr),
		.rd_data (gate_word)
	);

	label_gen u_gen (
		.clk   (clk),
		.rst   (rst),
		.load  (gen_load),
		.seed  (seed),
		.step  (gen_step),
		.label (gen_label)
	);

	wire_labels u_labels (
		.clk       (clk),
		.wr_en     (lbl_wr_en),
		.wr_addr   (lbl_wr_addr),
		.wr_data   (lbl_wr_data),
		.rd_addr_0 (lbl_rd_addr_0),
		.rd_addr_1 (lbl_rd_addr_1),
		.rd_data_0 (lbl_rd_data_0),
		.rd_data_1 (lbl_rd_data_1)
	);

	gc_garbler u_garbler (.*);   // Drives the output stream

endmodule

/* src/gc_garbler.sv */
// Free-XOR garbler FSM that draws labels, evaluates gates, builds the output mask and streams
`include "gc_cfg.svh"

module gc_garbler (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  gc_pkg::wire_idx_t   num_in,
	input  gc_pkg::gate_idx_t   num_gates,
	input  gc_pkg::wire_idx_t   num_out,
	output logic                busy,
	output logic                done,
	output gc_pkg::gate_idx_t   gate_addr,
	input  gc_pkg::gate_word_t  gate_word,
	output logic                gen_load,
	output logic                gen_step,
	input  gc_pkg::label_t      gen_label,
	output logic                lbl_wr_en,
	output gc_pkg::wire_idx_t   lbl_wr_addr,
	output gc_pkg::label_t      lbl_wr_data,
	output gc_pkg::wire_idx_t   lbl_rd_addr_0,
	output gc_pkg::wire_idx_t   lbl_rd_addr_1,
	input  gc_pkg::label_t      lbl_rd_data_0,
	input  gc_pkg::label_t      lbl_rd_data_1,
	output gc_pkg::tag_t        out_tag,
	output gc_pkg::wire_idx_t   out_index,
	output gc_pkg::label_t      out_data
);
	import gc_pkg::*;

	localparam int MASK_IDX_W = $clog2(`GC_MAX_OUT);

	garble_state_t         state;
	label_t                r;            // Global offset
	label_t                r_next;
	label_t                mask;
	label_t                gate_label;
	wire_idx_t             cnt;          // Wire counter for drawing and mask reads
	wire_idx_t             gate_wire;
	wire_idx_t             out_base;
	gate_idx_t             gate_cnt;
	gate_op_t              gate_op;
	logic                  rd_pend;      // Mask read in flight
	logic [MASK_IDX_W-1:0] mask_bit;

	assign busy      = (state != IDLE) && (state != DONE);
	assign done      = (state == DONE);
	assign r_next    = {gen_label[`GC_LABEL_W-1:1], 1'b1};   // Point-and-permute bit
	assign gate_op   = gate_op_t'(gate_word[17:16]);
	assign gate_wire = num_in + wire_idx_t'(2) + wire_idx_t'(gate_cnt);
	// Outputs are the last num_out gates
	assign out_base  = num_in + wire_idx_t'(2) + wire_idx_t'(num_gates) - num_out;

	always_comb begin
		case (gate_op)
			GATE_XNOR: gate_label = lbl_rd_data_0 ^ lbl_rd_data_1 ^ r;
			GATE_NOT:  gate_label = lbl_rd_data_0 ^ r;
			default:   gate_label = lbl_rd_data_0 ^ lbl_rd_data_1;
		endcase
	end

	always_comb begin
		gen_load      = start && !busy;
		gen_step      = (state == DRAW_R) || (state == DRAW_LABELS);
		gate_addr     = gate_cnt;
		lbl_wr_en     = 1'b0;
		lbl_wr_addr   = cnt;
		lbl_wr_data   = gen_label;
		lbl_rd_addr_0 = gate_word[15:8];
		lbl_rd_addr_1 = gate_word[7:0];
		case (state)
			DRAW_LABELS: lbl_wr_en = 1'b1;
			WRITE_GATE: begin
				gate_addr   = gate_cnt + 1'b1;   // Next gate word is ready in READ_GATE
				lbl_wr_en   = 1'b1;
				lbl_wr_addr = gate_wire;
				lbl_wr_data = gate_label;
			end
			MASK: lbl_rd_addr_0 = out_base + cnt;
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= IDLE;
			cnt      <= '0;
			gate_cnt <= '0;
			r        <= '0;
			mask     <= '0;
			rd_pend  <= 1'b0;
			out_tag  <= TAG_NONE;
		end else begin
			out_tag <= TAG_NONE;
			rd_pend <= 1'b0;
			if (rd_pend)
				mask[mask_bit] <= lbl_rd_data_0[0];

			case (state)
				IDLE, DONE: begin
					if (start) begin
						state    <= DRAW_R;
						cnt      <= '0;
						gate_cnt <= '0;
						mask     <= '0;
					end
				end
				DRAW_R: begin
					r       <= r_next;
					out_tag <= TAG_R;
					state   <= DRAW_LABELS;
				end
				DRAW_LABELS: begin
					out_tag <= TAG_LABEL;
					cnt     <= cnt + 1'b1;
					if (cnt == num_in + wire_idx_t'(1)) begin
						cnt   <= '0;
						state <= (num_gates == '0) ? MASK : READ_GATE;
					end
				end
				READ_GATE: state <= WRITE_GATE;
				WRITE_GATE: begin
					gate_cnt <= gate_cnt + 1'b1;
					state    <= (gate_cnt == num_gates - 1'b1) ? MASK : READ_GATE;
				end
				MASK: begin
					if (cnt != num_out) begin
						cnt     <= cnt + 1'b1;
						rd_pend <= 1'b1;
					end else if (!rd_pend) begin
						out_tag <= TAG_MASK;   // Last mask bit landed the cycle before
						state   <= DONE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		mask_bit <= cnt[MASK_IDX_W-1:0];
		case (state)
			DRAW_R: begin
				out_index <= '0;
				out_data  <= r_next;
			end
			DRAW_LABELS: begin
				out_index <= cnt;
				out_data  <= gen_label;
			end
			MASK: begin
				out_index <= '0;
				out_data  <= mask;
			end
			default: ;
		endcase
	end

	// The host must keep the output count within one mask word
	assert property (@(posedge clk) disable iff (rst) start |-> num_out <= `GC_MAX_OUT);

endmodule

/* src/wire_labels.sv */
// Zero-label memory indexed by wire number with one write port and two synchronous read ports
`include "gc_cfg.svh"

module wire_labels (
	input  logic                clk,
	input  logic                wr_en,
	input  gc_pkg::wire_idx_t   wr_addr,
	input  gc_pkg::label_t      wr_data,
	input  gc_pkg::wire_idx_t   rd_addr_0,
	input  gc_pkg::wire_idx_t   rd_addr_1,
	output gc_pkg::label_t      rd_data_0,
	output gc_pkg::label_t      rd_data_1
);
	import gc_pkg::*;

	localparam int DEPTH = 1 << `GC_WIRE_W;

	label_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Both gate inputs are fetched in the same cycle
	always_ff @(posedge clk) begin
		rd_data_0 <= mem[rd_addr_0];
		rd_data_1 <= mem[rd_addr_1];
	end

endmodule

/* src/label_gen.sv */
// Label generator built on a xorshift32 register, seeded on load and stepped on demand
module label_gen (
	input  logic            clk,
	input  logic            rst,
	input  logic            load,
	input  gc_pkg::label_t  seed,
	input  logic            step,
	output gc_pkg::label_t  label
);
	import gc_pkg::*;

	label_t state;

	// Next value is visible before the step commits it
	always_comb begin
		label = state ^ (state << 13);
		label = label ^ (label >> 17);
		label = label ^ (label << 5);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= '0;
		else if (load)
			state <= seed;
		else if (step)
			state <= label;
	end

	// Zero is a fixed point of xorshift
	assert property (@(posedge clk) disable iff (rst) load |-> seed != '0);

endmodule

/* src/netlist_mem.sv */
// Netlist memory holding one gate word per gate index with a synchronous read
`include "gc_cfg.svh"

module netlist_mem (
	input  logic                clk,
	input  logic                wr_en,
	input  gc_pkg::gate_idx_t   wr_addr,
	input  gc_pkg::gate_word_t  wr_data,
	input  gc_pkg::gate_idx_t   rd_addr,
	output gc_pkg::gate_word_t  rd_data
);
	import gc_pkg::*;

	localparam int DEPTH = 1 << `GC_GATE_W;

	gate_word_t mem [DEPTH];

	// Written by the host while idle, read by the garbler every cycle
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

/* src/gc_regs.sv */
// Garbler AXI4-Lite register block with configuration, start pulse, status and netlist port
`include "gc_cfg.svh"

module gc_regs (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [`GC_AXI_ADDR_W-1:0]   awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [31:0]                 wdata,
	input  logic [3:0]                  wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [1:0]                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [`GC_AXI_ADDR_W-1:0]   araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [31:0]                 rdata,
	output logic [1:0]                  rresp,
	output logic                        rvalid,
	input  logic                        rready,
	output logic                        start,
	output gc_pkg::label_t              seed,
	output gc_pkg::wire_idx_t           num_in,
	output gc_pkg::gate_idx_t           num_gates,
	output gc_pkg::wire_idx_t           num_out,
	output logic                        gate_wr_en,
	output gc_pkg::gate_idx_t           gate_wr_addr,
	output gc_pkg::gate_word_t          gate_wr_data,
	input  logic                        busy,
	input  logic                        done
);
	import gc_pkg::*;

	logic        wr_fire;
	logic        rd_fire;
	logic [31:0] wr_old;
	logic [31:0] wr_val;

	function automatic logic [31:0] reg_value(input logic [`GC_AXI_ADDR_W-1:0] addr);
		logic [31:0] v;
		case (addr)
			`GC_REG_STATUS:    v = {30'd0, done, busy};
			`GC_REG_SEED:      v = 32'(seed);
			`GC_REG_NUM_IN:    v = 32'(num_in);
			`GC_REG_NUM_GATES: v = 32'(num_gates);
			`GC_REG_NUM_OUT:   v = 32'(num_out);
			`GC_REG_GATE_ADDR: v = 32'(gate_wr_addr);
			default:           v = '0;   // CTRL and GATE_DATA read back as zero
		endcase
		return v;
	endfunction

	// Address and data are taken together in one cycle
	assign wr_fire = awvalid && wvalid && !bvalid;
	assign rd_fire = arvalid && !rvalid;
	assign awready = !bvalid;
	assign wready  = !bvalid;
	assign arready = !rvalid;
	assign bresp   = 2'b00;   // OKAY
	assign rresp   = 2'b00;

	// Byte lanes not strobed keep the current value
	always_comb begin
		wr_old = reg_value(awaddr);
		for (int i = 0; i < 4; i++)
			wr_val[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : wr_old[8*i +: 8];
	end

	assign gate_wr_en   = wr_fire && (awaddr == `GC_REG_GATE_DATA);
	assign gate_wr_data = wr_val[$bits(gate_word_t)-1:0];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bvalid       <= 1'b0;
			rvalid       <= 1'b0;
			start        <= 1'b0;
			seed         <= '0;
			num_in       <= '0;
			num_gates    <= '0;
			num_out      <= '0;
			gate_wr_addr <= '0;
		end else begin
			// Start is dropped while a run is in progress
			start <= wr_fire && (awaddr == `GC_REG_CTRL) && wr_val[0] && !busy;

			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;

			if (wr_fire) begin
				case (awaddr)
					`GC_REG_SEED:      seed <= wr_val[$bits(label_t)-1:0];
					`GC_REG_NUM_IN:    num_in <= wr_val[$bits(wire_idx_t)-1:0];
					`GC_REG_NUM_GATES: num_gates <= wr_val[$bits(gate_idx_t)-1:0];
					`GC_REG_NUM_OUT:   num_out <= wr_val[$bits(wire_idx_t)-1:0];
					`GC_REG_GATE_ADDR: gate_wr_addr <= wr_val[$bits(gate_idx_t)-1:0];
					`GC_REG_GATE_DATA: gate_wr_addr <= gate_wr_addr + 1'b1;   // Auto increment
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire)
			rdata <= reg_value(araddr);
	end

	// A request stays valid until it is taken
	assert property (@(posedge clk) disable iff (rst)
		awvalid && !wr_fire |=> awvalid);
	assert property (@(posedge clk) disable iff (rst)
		wvalid && !wr_fire |=> wvalid);
	assert property (@(posedge clk) disable iff (rst)
		arvalid && !rd_fire |=> arvalid);

endmodule

/* src/gc_pkg.sv */
// Garbler package with label, wire, gate and stream tag types and the FSM states
`include "gc_cfg.svh"

package gc_pkg;

	typedef logic [`GC_LABEL_W-1:0] label_t;
	typedef logic [`GC_WIRE_W-1:0]  wire_idx_t;  // 0 and 1 constants, then inputs, then gates
	typedef logic [`GC_GATE_W-1:0]  gate_idx_t;

	typedef enum logic [1:0] {
		GATE_XOR  = 2'd0,
		GATE_XNOR = 2'd1,
		GATE_NOT  = 2'd2
	} gate_op_t;

	// Op in 17:16, input 0 in 15:8, input 1 in 7:0
	typedef logic [17:0] gate_word_t;

	typedef enum logic [1:0] {
		TAG_NONE  = 2'd0,
		TAG_R     = 2'd1,
		TAG_LABEL = 2'd2,
		TAG_MASK  = 2'd3
	} tag_t;

	typedef enum logic [2:0] {
		IDLE,
		DRAW_R,
		DRAW_LABELS,
		READ_GATE,
		WRITE_GATE,
		MASK,
		DONE
	} garble_state_t;

endpackage

/* src/gc_cfg.svh */
// Garbler configuration with label and index widths, limits and register offsets
`ifndef GC_CFG_SVH
`define GC_CFG_SVH

`define GC_LABEL_W       32
`define GC_WIRE_W        8     // Up to 256 wires
`define GC_GATE_W        8
`define GC_MAX_OUT       32    // Output mask fits in one label

`define GC_AXI_ADDR_W    6

// AXI4-Lite byte offsets
`define GC_REG_CTRL      6'h00
`define GC_REG_STATUS    6'h04
`define GC_REG_SEED      6'h08
`define GC_REG_NUM_IN    6'h0C
`define GC_REG_NUM_GATES 6'h10
`define GC_REG_NUM_OUT   6'h14
`define GC_REG_GATE_ADDR 6'h18
`define GC_REG_GATE_DATA 6'h1C

`endif
